//--- flist.f
logic/p4_app_pkg.sv
logic/fwd_table_regs.sv
logic/ingress_lookup.sv
logic/egress_switch.sv
logic/p4_app.sv
tests/p4_app_properties.sv
tests/tb.sv

//--- logic/egress_switch.sv
module egress_switch
    import p4_app_pkg::*;
#(
    parameter int OUT_CREDITS = 3
) (
    input  logic      axil_if,
    input  logic      rst_n,
    input  logic      fwd0_valid,
    input  pkt_data_t fwd0_data,
    input  port_t     fwd0_egress,
    input  logic      fwd1_valid,
    input  pkt_data_t fwd1_data,
    input  port_t     fwd1_egress,
    input  logic      out0_credit,
    input  logic      out1_credit,
    output logic      fwd0_ready,
    output logic      fwd1_ready,
    output logic      out0_valid,
    output pkt_data_t out0_data,
    output port_t     out0_src,
    output tstamp_t   out0_tstamp,
    output logic      out1_valid,
    output pkt_data_t out1_data,
    output port_t     out1_src,
    output tstamp_t   out1_tstamp
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    // Indexed [output][ingress]
    logic [1:0][1:0] req;
    logic [1:0][1:0] grant;
    port_t [1:0] win;
    port_t [1:0] rr;
    logic [1:0] send;
    logic [1:0] credit_ret;
    logic [1:0][CW-1:0] credit_cnt;

    tstamp_t ts;

    // Output stage
    logic [1:0] out_v;
    pkt_data_t [1:0] out_d;
    port_t [1:0] out_s;
    tstamp_t [1:0] out_t;

    assign credit_ret = {out1_credit, out0_credit};

    // ======================================================================
    // Arbitration per output
    // ======================================================================

    always_comb begin
        for (int o = 0; o < 2; o++) begin
            req[o][0] = fwd0_valid && (fwd0_egress == port_t'(o));
            req[o][1] = fwd1_valid && (fwd1_egress == port_t'(o));
            // Pointer only matters when both ingress stages collide
            if (&req[o]) begin
                win[o] = rr[o];
            end else begin
                win[o] = port_t'(req[o][1]);
            end
            send[o]  = (|req[o]) && (credit_cnt[o] != '0);
            grant[o] = send[o] ? (2'b01 << win[o]) : 2'b00;
        end
    end

    // An ingress stage is ready when either output grants it
    assign fwd0_ready = grant[0][0] || grant[1][0];
    assign fwd1_ready = grant[0][1] || grant[1][1];

    // ======================================================================
    // Credits, pointers and timestamp
    // ======================================================================

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            ts         <= '0;
            out_v      <= '0;
            rr         <= '0;
            credit_cnt <= {2{CW'(OUT_CREDITS)}};
        end else begin
            ts <= ts + 1'b1;
            for (int o = 0; o < 2; o++) begin
                out_v[o] <= send[o];
                if (send[o]) begin
                    rr[o] <= ~win[o];
                end
                case ({send[o], credit_ret[o]})
                    2'b10:   credit_cnt[o] <= credit_cnt[o] - 1'b1;
                    2'b01:   credit_cnt[o] <= credit_cnt[o] + 1'b1;
                    default: credit_cnt[o] <= credit_cnt[o];
                endcase
            end
        end
    end

    always_ff @(posedge axil_if) begin
        for (int o = 0; o < 2; o++) begin
            if (send[o]) begin
                out_d[o] <= win[o] ? fwd1_data : fwd0_data;
                out_s[o] <= win[o];
                // Value the counter holds once out_valid is up
                out_t[o] <= ts + 1'b1;
            end
        end
    end

    assign out0_valid  = out_v[0];
    assign out0_data   = out_d[0];
    assign out0_src    = out_s[0];
    assign out0_tstamp = out_t[0];
    assign out1_valid  = out_v[1];
    assign out1_data   = out_d[1];
    assign out1_src    = out_s[1];
    assign out1_tstamp = out_t[1];

endmodule

//--- logic/fwd_table_regs.sv
module fwd_table_regs
    import p4_app_pkg::*;
(
    input  logic      axil_if,
    input  logic      rst_n,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    input  fwd_key_t  lookup_key0,
    input  fwd_key_t  lookup_key1,
    input  logic      drop0,
    input  logic      drop1,
    output reg_data_t reg_rdata,
    output logic      reg_rvalid,
    output logic      entry_valid0,
    output port_t     entry_port0,
    output logic      entry_valid1,
    output port_t     entry_port1
);

    logic [FWD_ENTRIES-1:0] tbl_valid;
    port_t [FWD_ENTRIES-1:0] tbl_port;
    reg_data_t [1:0] drop_cnt;
    logic [1:0] drop_vec;

    reg_addr_t tbl_off;
    logic tbl_hit;
    fwd_key_t tbl_idx;
    reg_data_t rd_word;

    // ======================================================================
    // Address decode and read mux
    // ======================================================================

    always_comb begin
        tbl_off = reg_addr - REG_FWD_BASE;
        // Word aligned and inside the table window
        tbl_hit = (int'(tbl_off) < FWD_ENTRIES * REG_FWD_STRIDE) &&
                  ((int'(tbl_off) % REG_FWD_STRIDE) == 0);
        tbl_idx = fwd_key_t'(int'(tbl_off) / REG_FWD_STRIDE);

        rd_word = '0;
        if (tbl_hit) begin
            rd_word[FWD_VALID_BIT] = tbl_valid[tbl_idx];
            rd_word[FWD_PORT_BIT]  = tbl_port[tbl_idx];
        end else if (reg_addr == REG_DROP_CNT0) begin
            rd_word = drop_cnt[0];
        end else if (reg_addr == REG_DROP_CNT1) begin
            rd_word = drop_cnt[1];
        end
    end

    // ======================================================================
    // Table storage
    // ======================================================================

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            tbl_valid <= '0;
        end else if (reg_wr && tbl_hit) begin
            tbl_valid[tbl_idx] <= reg_wdata[FWD_VALID_BIT];
        end
    end

    always_ff @(posedge axil_if) begin
        if (reg_wr && tbl_hit) begin
            tbl_port[tbl_idx] <= reg_wdata[FWD_PORT_BIT];
        end
    end

    // Two combinational lookup ports
    assign entry_valid0 = tbl_valid[lookup_key0];
    assign entry_port0  = tbl_port[lookup_key0];
    assign entry_valid1 = tbl_valid[lookup_key1];
    assign entry_port1  = tbl_port[lookup_key1];

    // ======================================================================
    // Drop counters and read response
    // ======================================================================

    assign drop_vec = {drop1, drop0};

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            drop_cnt   <= '0;
            reg_rvalid <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // Saturate at all ones
                if (drop_vec[i] && (drop_cnt[i] != '1)) begin
                    drop_cnt[i] <= drop_cnt[i] + 1'b1;
                end
            end
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge axil_if) begin
        if (reg_rd) begin
            reg_rdata <= rd_word;
        end
    end

endmodule

//--- logic/ingress_lookup.sv
module ingress_lookup
    import p4_app_pkg::*;
#(
    parameter int IN_CREDITS = 4
) (
    input  logic      axil_if,
    input  logic      rst_n,
    input  logic      in_valid,
    input  pkt_data_t in_data,
    input  logic      entry_valid,
    input  port_t     entry_port,
    input  logic      fwd_ready,
    output logic      in_credit,
    output fwd_key_t  lookup_key,
    output logic      drop,
    output logic      fwd_valid,
    output pkt_data_t fwd_data,
    output port_t     fwd_egress
);

    localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
    localparam int CNT_W = $clog2(IN_CREDITS + 1);

    pkt_data_t fifo_mem [IN_CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;
    logic pop;
    logic slot_free;

    pkt_data_t lkp_data;
    logic lkp_full;
    lookup_state_e state;
    port_t hold_port;

    // ======================================================================
    // Lookup decision
    // ======================================================================

    assign lookup_key = fwd_key_t'(lkp_data[$bits(fwd_key_t)-1:0]);

    // Table is only consulted on the first cycle and HOLD reuses the latched port
    assign drop       = lkp_full && (state == IDLE) && !entry_valid;
    assign fwd_valid  = lkp_full && ((state == HOLD) || entry_valid);
    assign fwd_egress = (state == HOLD) ? hold_port : entry_port;
    assign fwd_data   = lkp_data;

    // Lookup register empties this cycle, so the next beat may move in
    assign slot_free = !lkp_full || drop || (fwd_valid && fwd_ready);
    assign pop       = (fifo_cnt != '0) && slot_free;

    // ======================================================================
    // Input FIFO
    // ======================================================================

    always_ff @(posedge axil_if) begin
        if (in_valid) begin
            fifo_mem[wr_ptr] <= in_data;
        end
        if (pop) begin
            lkp_data <= fifo_mem[rd_ptr];
        end
        if ((state == IDLE) && fwd_valid && !fwd_ready) begin
            hold_port <= entry_port;
        end
    end

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fifo_cnt  <= '0;
            lkp_full  <= 1'b0;
            state     <= IDLE;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase

            if (pop) begin
                lkp_full <= 1'b1;
            end else if (slot_free) begin
                lkp_full <= 1'b0;
            end

            case (state)
                IDLE: if (fwd_valid && !fwd_ready) state <= HOLD;
                HOLD: if (fwd_ready) state <= IDLE;
                default: state <= IDLE;
            endcase

            // One credit back per beat leaving the FIFO
            in_credit <= pop;
        end
    end

endmodule

//--- logic/p4_app.sv
module p4_app
    import p4_app_pkg::*;
#(
    parameter int IN_CREDITS  = 4,
    parameter int OUT_CREDITS = 3
) (
    input  logic      axil_if,
    input  logic      rst_n,
    input  logic      in0_valid,
    input  pkt_data_t in0_data,
    input  logic      in1_valid,
    input  pkt_data_t in1_data,
    input  logic      out0_credit,
    input  logic      out1_credit,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    output logic      in0_credit,
    output logic      in1_credit,
    output logic      out0_valid,
    output pkt_data_t out0_data,
    output port_t     out0_src,
    output tstamp_t   out0_tstamp,
    output logic      out1_valid,
    output pkt_data_t out1_data,
    output port_t     out1_src,
    output tstamp_t   out1_tstamp,
    output reg_data_t reg_rdata,
    output logic      reg_rvalid
);

    fwd_key_t  lookup_key0;
    fwd_key_t  lookup_key1;
    logic      entry_valid0;
    logic      entry_valid1;
    port_t     entry_port0;
    port_t     entry_port1;
    logic      drop0;
    logic      drop1;
    logic      fwd0_valid;
    logic      fwd1_valid;
    logic      fwd0_ready;
    logic      fwd1_ready;
    pkt_data_t fwd0_data;
    pkt_data_t fwd1_data;
    port_t     fwd0_egress;
    port_t     fwd1_egress;

    // ======================================================================
    // Table and register port
    // ======================================================================

    fwd_table_regs i_fwd_table_regs (
        .axil_if      (axil_if),
        .rst_n        (rst_n),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .lookup_key0  (lookup_key0),
        .lookup_key1  (lookup_key1),
        .drop0        (drop0),
        .drop1        (drop1),
        .reg_rdata    (reg_rdata),
        .reg_rvalid   (reg_rvalid),
        .entry_valid0 (entry_valid0),
        .entry_port0  (entry_port0),
        .entry_valid1 (entry_valid1),
        .entry_port1  (entry_port1)
    );

    // ======================================================================
    // Ingress stages
    // ======================================================================

    // Port 0 feeds the switch's fwd0 side
    ingress_lookup #(.IN_CREDITS(IN_CREDITS)) i_ingress_lookup_0 (
        .axil_if     (axil_if),
        .rst_n       (rst_n),
        .in_valid    (in0_valid),
        .in_data     (in0_data),
        .entry_valid (entry_valid0),
        .entry_port  (entry_port0),
        .fwd_ready   (fwd0_ready),
        .in_credit   (in0_credit),
        .lookup_key  (lookup_key0),
        .drop        (drop0),
        .fwd_valid   (fwd0_valid),
        .fwd_data    (fwd0_data),
        .fwd_egress  (fwd0_egress)
    );

    // Port 1 feeds the fwd1 side
    ingress_lookup #(.IN_CREDITS(IN_CREDITS)) i_ingress_lookup_1 (
        .axil_if     (axil_if),
        .rst_n       (rst_n),
        .in_valid    (in1_valid),
        .in_data     (in1_data),
        .entry_valid (entry_valid1),
        .entry_port  (entry_port1),
        .fwd_ready   (fwd1_ready),
        .in_credit   (in1_credit),
        .lookup_key  (lookup_key1),
        .drop        (drop1),
        .fwd_valid   (fwd1_valid),
        .fwd_data    (fwd1_data),
        .fwd_egress  (fwd1_egress)
    );

    // ======================================================================
    // Egress
    // ======================================================================

    egress_switch #(.OUT_CREDITS(OUT_CREDITS)) i_egress_switch (
        .axil_if     (axil_if),
        .rst_n       (rst_n),
        .fwd0_valid  (fwd0_valid),
        .fwd0_data   (fwd0_data),
        .fwd0_egress (fwd0_egress),
        .fwd1_valid  (fwd1_valid),
        .fwd1_data   (fwd1_data),
        .fwd1_egress (fwd1_egress),
        .out0_credit (out0_credit),
        .out1_credit (out1_credit),
        .fwd0_ready  (fwd0_ready),
        .fwd1_ready  (fwd1_ready),
        .out0_valid  (out0_valid),
        .out0_data   (out0_data),
        .out0_src    (out0_src),
        .out0_tstamp (out0_tstamp),
        .out1_valid  (out1_valid),
        .out1_data   (out1_data),
        .out1_src    (out1_src),
        .out1_tstamp (out1_tstamp)
    );

endmodule

//--- logic/p4_app_pkg.sv
package p4_app_pkg;

    // ======================================================================
    // Datapath types
    // ======================================================================

    // Single-beat packet
    typedef logic [63:0] pkt_data_t;

    // Lookup key from the low nibble of the beat
    typedef logic [3:0]  fwd_key_t;

    // Ingress or egress port number
    typedef logic        port_t;

    // Free-running egress timestamp
    typedef logic [31:0] tstamp_t;

    // ======================================================================
    // Register bus and map
    // ======================================================================

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // One forwarding table word per key
    localparam int        FWD_ENTRIES    = 16;
    localparam int        REG_FWD_STRIDE = 4;
    localparam reg_addr_t REG_FWD_BASE   = 8'h00;

    // Bit positions inside a table word
    localparam int        FWD_PORT_BIT   = 0;
    localparam int        FWD_VALID_BIT  = 1;

    // Read-only drop counters
    localparam reg_addr_t REG_DROP_CNT0  = 8'h40;
    localparam reg_addr_t REG_DROP_CNT1  = 8'h44;

    // HOLD keeps a forwarded beat in the lookup stage until the switch takes it
    typedef enum logic {IDLE, HOLD} lookup_state_e;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -Wno-fatal --top-module tb -f flist.f

# The simulation exits nonzero on failure, so capture its output either way
output=$(./obj_dir/Vtb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- tests/p4_app_properties.sv
module p4_app_properties #(
    parameter int OUT_CREDITS = 3,
    parameter int CW          = $clog2(OUT_CREDITS + 1)
) (
    input logic               axil_if,
    input logic               rst_n,
    input logic               out0_valid,
    input logic               out1_valid,
    input logic               fwd0_ready,
    input logic               fwd1_ready,
    input logic [1:0][CW-1:0] credit_cnt
);

    // ======================================================================
    // Egress credits
    // ======================================================================

    // A beat leaves only if the counter was nonzero on its send edge
    out0_sent_with_credit: assert property (@(posedge axil_if) disable iff (!rst_n)
        out0_valid |-> ($past(credit_cnt[0]) != '0))
        else $error("out0_valid raised with no egress credit");

    out1_sent_with_credit: assert property (@(posedge axil_if) disable iff (!rst_n)
        out1_valid |-> ($past(credit_cnt[1]) != '0))
        else $error("out1_valid raised with no egress credit");

    credit0_bounded: assert property (@(posedge axil_if) disable iff (!rst_n)
        credit_cnt[0] <= CW'(OUT_CREDITS))
        else $error("out0 credit counter above its start value");

    credit1_bounded: assert property (@(posedge axil_if) disable iff (!rst_n)
        credit_cnt[1] <= CW'(OUT_CREDITS))
        else $error("out1 credit counter above its start value");

    // No transfer is accepted during reset
    ready_low_in_reset: assert property (@(posedge axil_if)
        !rst_n |-> (!fwd0_ready && !fwd1_ready))
        else $error("fwd_ready high during reset");

endmodule

bind egress_switch p4_app_properties #(.OUT_CREDITS(OUT_CREDITS)) i_p4_app_properties (
    .axil_if    (axil_if),
    .rst_n      (rst_n),
    .out0_valid (out0_valid),
    .out1_valid (out1_valid),
    .fwd0_ready (fwd0_ready),
    .fwd1_ready (fwd1_ready),
    .credit_cnt (credit_cnt)
);

//--- tests/tb.sv
module tb
    import p4_app_pkg::*;
;

    localparam int IN_CREDITS  = 4;
    localparam int OUT_CREDITS = 3;
    localparam int ROWS        = 24;
    localparam int WATCHDOG    = ROWS * 40 + 200;

    logic       axil_if;
    logic       rst_n;
    logic [1:0] in_valid;
    pkt_data_t  in_data [2];
    logic [1:0] in_credit;
    logic [1:0] out_valid;
    pkt_data_t  out_data [2];
    port_t      out_src [2];
    tstamp_t    out_tstamp [2];
    logic [1:0] out_credit;
    logic       reg_wr;
    logic       reg_rd;
    reg_addr_t  reg_addr;
    reg_data_t  reg_wdata;
    reg_data_t  reg_rdata;
    logic       reg_rvalid;

    // Stimulus table with -1 as the expected egress of a drop
    port_t     row_port [ROWS];
    pkt_data_t row_data [ROWS];
    int        row_dest [ROWS];
    int        n_rows = 0;

    // Scoreboard queues indexed [ingress][egress]
    pkt_data_t exp_q [2][2][$];
    int drop_exp [2]     = '{default: 0};
    int sent [2]         = '{default: 0};
    int credit_total [2] = '{default: 0};
    int cred_left [2]    = '{IN_CREDITS, IN_CREDITS};
    int next_row [2]     = '{default: 0};
    int gap [2]          = '{default: 0};
    logic sending        = 1'b0;

    // Egress sink state
    int seen [2]         = '{default: 0};
    int returned [2]     = '{default: 0};
    int owed [2]         = '{default: 0};
    int hold_off [2]     = '{default: 0};
    tstamp_t last_ts [2] = '{default: '0};

    reg_data_t rd_word;

    p4_app #(.IN_CREDITS(IN_CREDITS), .OUT_CREDITS(OUT_CREDITS)) i_p4_app (
        .axil_if     (axil_if),
        .rst_n       (rst_n),
        .in0_valid   (in_valid[0]),
        .in0_data    (in_data[0]),
        .in1_valid   (in_valid[1]),
        .in1_data    (in_data[1]),
        .out0_credit (out_credit[0]),
        .out1_credit (out_credit[1]),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .in0_credit  (in_credit[0]),
        .in1_credit  (in_credit[1]),
        .out0_valid  (out_valid[0]),
        .out0_data   (out_data[0]),
        .out0_src    (out_src[0]),
        .out0_tstamp (out_tstamp[0]),
        .out1_valid  (out_valid[1]),
        .out1_data   (out_data[1]),
        .out1_src    (out_src[1]),
        .out1_tstamp (out_tstamp[1]),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid)
    );

    // ======================================================================
    // Reference model and helpers
    // ======================================================================

    // Keys 0-5 to port 0, 6-11 to port 1, the rest invalid
    function automatic int route_of(input fwd_key_t k);
        if (k < 6) return 0;
        if (k < 12) return 1;
        return -1;
    endfunction

    function automatic reg_data_t table_word(input int k);
        reg_data_t w;
        w = '0;
        w[FWD_VALID_BIT] = (route_of(fwd_key_t'(k)) >= 0);
        w[FWD_PORT_BIT]  = (route_of(fwd_key_t'(k)) == 1);
        return w;
    endfunction

    function automatic logic queues_empty();
        for (int s = 0; s < 2; s++) begin
            for (int d = 0; d < 2; d++) begin
                if (exp_q[s][d].size() != 0) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic add_row(input port_t p, input fwd_key_t k);
        row_port[n_rows] = p;
        row_data[n_rows] = {7'h0, p, 8'(n_rows), 44'h5a5_a5a5_a5a5, k};
        row_dest[n_rows] = route_of(k);
        n_rows++;
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge axil_if);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge axil_if);
        reg_wr    <= 1'b0;
    endtask

    // Response must show up exactly one cycle after the strobe
    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge axil_if);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge axil_if);
        reg_rd   <= 1'b0;
        check_value("reg_rvalid before response", reg_rvalid, 1'b0);
        @(posedge axil_if);
        check_value("reg_rvalid", reg_rvalid, 1'b1);
        data = reg_rdata;
    endtask

    // ======================================================================
    // Clock, watchdog, sender and sink
    // ======================================================================

    initial begin
        axil_if = 1'b0;
        forever #4 axil_if = ~axil_if;
    end

    initial begin
        repeat (WATCHDOG) @(posedge axil_if);
        stop_with_failure("Timeout: beats or credits still outstanding at watchdog expiry");
    end

    // One process drives both ingress ports and tracks their credits
    always @(posedge axil_if) begin
        for (int p = 0; p < 2; p++) begin
            in_valid[p] <= 1'b0;
            if (in_credit[p]) begin
                cred_left[p]++;
                credit_total[p]++;
            end
            if (sending) begin
                while (next_row[p] < n_rows && row_port[next_row[p]] != port_t'(p)) begin
                    next_row[p]++;
                end
                if (next_row[p] < n_rows) begin
                    if (gap[p] > 0) begin
                        gap[p]--;
                    end else if (cred_left[p] > 0) begin
                        in_valid[p] <= 1'b1;
                        in_data[p]  <= row_data[next_row[p]];
                        cred_left[p]--;
                        sent[p]++;
                        if (row_dest[next_row[p]] < 0) begin
                            drop_exp[p]++;
                        end else begin
                            exp_q[p][row_dest[next_row[p]]].push_back(row_data[next_row[p]]);
                        end
                        next_row[p]++;
                        gap[p] = $urandom_range(0, 2);
                    end
                end
            end
        end
    end

    // Egress checks plus a sink that withholds credits for random spans
    always @(posedge axil_if) begin
        pkt_data_t expd;
        fwd_key_t  key;
        for (int o = 0; o < 2; o++) begin
            out_credit[o] <= 1'b0;
            if (out_valid[o]) begin
                seen[o]++;
                key = fwd_key_t'(out_data[o][3:0]);
                check_value($sformatf("out%0d beats within credits", o),
                            seen[o] <= OUT_CREDITS + returned[o], 1'b1);
                check_value($sformatf("out%0d egress for key %0d", o, key), o, route_of(key));
                if (exp_q[out_src[o]][o].size() == 0) begin
                    stop_with_failure($sformatf("Beat on out%0d from in%0d was not expected",
                                                o, out_src[o]));
                end
                expd = exp_q[out_src[o]][o].pop_front();
                check_value($sformatf("out%0d_data", o), out_data[o], expd);
                if (seen[o] > 1) begin
                    check_value($sformatf("out%0d_tstamp rising", o),
                                out_tstamp[o] > last_ts[o], 1'b1);
                end
                last_ts[o] = out_tstamp[o];
                owed[o]++;
            end
            if (owed[o] > 0) begin
                if (hold_off[o] > 0) begin
                    hold_off[o]--;
                end else begin
                    out_credit[o] <= 1'b1;
                    owed[o]--;
                    returned[o]++;
                    hold_off[o] = $urandom_range(0, 7);
                end
            end
        end
    end

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        void'($urandom(8));
        in_valid   = '0;
        in_data    = '{default: '0};
        out_credit = '0;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        rst_n     <= 1'b0;

        // Ingress port and key per row
        add_row(1'b0, 4'd0);
        add_row(1'b1, 4'd8);
        add_row(1'b0, 4'd7);
        add_row(1'b1, 4'd4);
        add_row(1'b0, 4'd12);
        add_row(1'b1, 4'd14);
        add_row(1'b0, 4'd3);
        add_row(1'b1, 4'd10);
        add_row(1'b0, 4'd9);
        add_row(1'b1, 4'd0);
        add_row(1'b0, 4'd15);
        add_row(1'b1, 4'd6);
        add_row(1'b0, 4'd5);
        add_row(1'b1, 4'd12);
        add_row(1'b0, 4'd6);
        add_row(1'b1, 4'd5);
        add_row(1'b0, 4'd1);
        add_row(1'b1, 4'd11);
        add_row(1'b0, 4'd13);
        add_row(1'b1, 4'd2);
        add_row(1'b0, 4'd11);
        add_row(1'b1, 4'd7);
        add_row(1'b0, 4'd2);
        add_row(1'b1, 4'd3);

        repeat (3) @(posedge axil_if);
        rst_n <= 1'b1;

        for (int k = 0; k < FWD_ENTRIES; k++) begin
            reg_write(reg_addr_t'(REG_FWD_BASE + k * REG_FWD_STRIDE), table_word(k));
        end
        for (int k = 0; k < FWD_ENTRIES; k++) begin
            reg_read(reg_addr_t'(REG_FWD_BASE + k * REG_FWD_STRIDE), rd_word);
            check_value($sformatf("table word %0d", k), rd_word, table_word(k));
        end
        reg_read(8'h80, rd_word);
        check_value("unmapped read", rd_word, '0);

        @(posedge axil_if);
        sending <= 1'b1;
        // Run until all rows are sent, all beats are out and all credits are back
        while (next_row[0] < n_rows || next_row[1] < n_rows || !queues_empty() ||
               credit_total[0] < sent[0] || credit_total[1] < sent[1]) begin
            @(posedge axil_if);
        end

        check_value("in0_credit pulses", credit_total[0], sent[0]);
        check_value("in1_credit pulses", credit_total[1], sent[1]);
        reg_read(REG_DROP_CNT0, rd_word);
        check_value("drop count in0", rd_word, drop_exp[0]);
        reg_read(REG_DROP_CNT1, rd_word);
        check_value("drop count in1", rd_word, drop_exp[1]);

        $display("Testbench passed");
        $finish;
    end

endmodule
